// File: hw/vga_timing_pkg.sv
package vga_timing_pkg;

  // ------------------------------
  // counter types
  // ------------------------------
  // bit 0 is the half-pixel phase, bits 10:1 the pixel column
  typedef logic [10:0] hcount_t;
  typedef logic [9:0]  vcount_t;

  // horizontal raster, in 50 MHz clocks
  localparam hcount_t h_active      = 11'd1280;
  localparam hcount_t h_front_porch = 11'd32;
  localparam hcount_t h_sync        = 11'd192;
  localparam hcount_t h_back_porch  = 11'd96;
  localparam hcount_t h_total       = h_active + h_front_porch + h_sync + h_back_porch;

  // vertical raster, in lines
  localparam vcount_t v_active      = 10'd480;
  localparam vcount_t v_front_porch = 10'd10;
  localparam vcount_t v_sync        = 10'd2;
  localparam vcount_t v_back_porch  = 10'd33;
  localparam vcount_t v_total       = v_active + v_front_porch + v_sync + v_back_porch;

  // sync pulse windows, inclusive
  localparam hcount_t hs_first = h_active + h_front_porch;
  localparam hcount_t hs_last  = hs_first + h_sync - 11'd1;
  localparam vcount_t vs_first = v_active + v_front_porch;
  localparam vcount_t vs_last  = vs_first + v_sync - 10'd1;

  // ------------------------------
  // raster position and sync group
  // ------------------------------
  typedef struct packed {
    hcount_t hcount;
    vcount_t vcount;
  } raster_pos_t;

  // hs and vs are active low
  typedef struct packed {
    logic hs;
    logic vs;
    logic blank_n;
    logic pix_clk;
  } sync_t;

  // levels held while in reset
  localparam sync_t sync_idle = '{hs: 1'b1, vs: 1'b1, blank_n: 1'b0, pix_clk: 1'b0};

endpackage

// File: hw/game_pkg.sv
package game_pkg;

  // ------------------------------
  // tile map
  // ------------------------------
  localparam int map_dim = 16;
  localparam int tile_px = 16;
  // side of the drawn map area in pixels
  localparam int map_px  = map_dim * tile_px;

  typedef logic [3:0] map_idx_t;

  // tile codes, writedata bits 1:0
  typedef logic [1:0] tile_t;

  localparam tile_t tile_empty = 2'd0;
  localparam tile_t tile_apple = 2'd1;
  localparam tile_t tile_head  = 2'd2;
  localparam tile_t tile_body  = 2'd3;

  // ------------------------------
  // register bus
  // ------------------------------
  typedef logic [2:0] bus_addr_t;

  localparam bus_addr_t reg_x    = 3'd0;
  localparam bus_addr_t reg_y    = 3'd1;
  localparam bus_addr_t reg_tile = 3'd2;

  // ------------------------------
  // border wall, in 32-pixel blocks
  // ------------------------------
  localparam int wall_px         = 32;
  localparam int wall_left_col   = 0;
  localparam int wall_right_col  = 19;
  localparam int wall_top_row    = 1;
  localparam int wall_bottom_row = 14;

  // ------------------------------
  // colours
  // ------------------------------
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  // rgb565 values padded with zero low bits
  localparam rgb_t color_black = 24'h000000;
  localparam rgb_t color_wall  = 24'h808080;
  localparam rgb_t color_apple = 24'hf80000;
  localparam rgb_t color_head  = 24'h00fc00;
  localparam rgb_t color_body  = 24'h008000;

endpackage

// File: hw/vga_timing.sv
`timescale 1ns/1ps

// 640x480 raster from a 50 MHz clock, one pixel every two clocks
module vga_timing (
  input  logic                        clk,
  input  logic                        reset,
  output vga_timing_pkg::raster_pos_t pos,
  output vga_timing_pkg::sync_t       sync
);

  vga_timing_pkg::hcount_t hcount;
  vga_timing_pkg::vcount_t vcount;
  logic end_of_line;
  logic end_of_field;

  // ------------------------------
  // raster counters
  // ------------------------------
  assign end_of_line  = (hcount == vga_timing_pkg::h_total - 11'd1);
  assign end_of_field = (vcount == vga_timing_pkg::v_total - 10'd1);

  // horizontal, one step per clock
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hcount <= '0;
    end else if (end_of_line) begin
      hcount <= '0;
    end else begin
      hcount <= hcount + 11'd1;
    end
  end

  // vertical, one step per line
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vcount <= '0;
    end else if (end_of_line) begin
      if (end_of_field) begin
        vcount <= '0;
      end else begin
        vcount <= vcount + 10'd1;
      end
    end
  end

  // ------------------------------
  // sync and blank decode
  // ------------------------------
  always_comb begin
    pos.hcount = hcount;
    pos.vcount = vcount;
    // sync pulses active low
    sync.hs = !((hcount >= vga_timing_pkg::hs_first) &&
                (hcount <= vga_timing_pkg::hs_last));
    sync.vs = !((vcount >= vga_timing_pkg::vs_first) &&
                (vcount <= vga_timing_pkg::vs_last));
    // visible area only
    sync.blank_n = (hcount < vga_timing_pkg::h_active) &&
                   (vcount < vga_timing_pkg::v_active);
    // 25 MHz pixel clock, rising edge mid-pixel
    sync.pix_clk = hcount[0];
  end

endmodule

// File: hw/tile_map.sv
`timescale 1ns/1ps

// 16x16 tile map, written over the register bus, read by raster position
module tile_map (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        chipselect,
  input  logic                        write,
  input  game_pkg::bus_addr_t         address,
  input  logic [7:0]                  writedata,
  input  vga_timing_pkg::raster_pos_t pos,
  output game_pkg::tile_t             tile
);

  // latched write coordinates
  game_pkg::map_idx_t col_q;
  game_pkg::map_idx_t row_q;
  logic               wr_en;

  // mem[row][col]
  game_pkg::tile_t mem [game_pkg::map_dim][game_pkg::map_dim];

  logic [9:0]         px_col;
  logic               in_map;
  game_pkg::map_idx_t rd_col;
  game_pkg::map_idx_t rd_row;

  // ------------------------------
  // bus side
  // ------------------------------
  assign wr_en = chipselect && write;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      col_q <= '0;
      row_q <= '0;
    end else if (wr_en) begin
      case (address)
        game_pkg::reg_x: col_q <= writedata[3:0];
        game_pkg::reg_y: row_q <= writedata[3:0];
        default: ;
      endcase
    end
  end

  // tile store uses coordinates latched by earlier writes
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int r = 0; r < game_pkg::map_dim; r++) begin
        for (int c = 0; c < game_pkg::map_dim; c++) begin
          mem[r][c] <= game_pkg::tile_empty;
        end
      end
    end else if (wr_en && (address == game_pkg::reg_tile)) begin
      mem[row_q][col_q] <= writedata[1:0];
    end
  end

  // ------------------------------
  // pixel side, combinational
  // ------------------------------
  assign px_col = pos.hcount[10:1];
  assign in_map = (px_col < game_pkg::map_px) && (pos.vcount < game_pkg::map_px);
  assign rd_col = game_pkg::map_idx_t'(px_col / game_pkg::tile_px);
  assign rd_row = game_pkg::map_idx_t'(pos.vcount / game_pkg::tile_px);

  // outside the map counts as empty
  assign tile = in_map ? mem[rd_row][rd_col] : game_pkg::tile_empty;

endmodule

// File: hw/pixel_renderer.sv
`timescale 1ns/1ps

// picks the pixel colour and registers it with the sync levels
module pixel_renderer (
  input  logic                        clk,
  input  logic                        reset,
  input  vga_timing_pkg::raster_pos_t pos,
  input  vga_timing_pkg::sync_t       sync,
  input  game_pkg::tile_t             tile,
  output game_pkg::rgb_t              rgb,
  output vga_timing_pkg::sync_t       sync_out
);

  logic [9:0]     px_col;
  logic [4:0]     blk_col;
  logic [4:0]     blk_row;
  logic           side_wall;
  logic           flat_wall;
  logic           is_wall;
  game_pkg::rgb_t color_d;

  // ------------------------------
  // wall geometry
  // ------------------------------
  assign px_col  = pos.hcount[10:1];
  // 32-pixel block coordinates
  assign blk_col = 5'(px_col / game_pkg::wall_px);
  assign blk_row = 5'(pos.vcount / game_pkg::wall_px);

  // left and right columns, only below the top wall row
  assign side_wall = ((blk_col == 5'(game_pkg::wall_left_col)) ||
                      (blk_col == 5'(game_pkg::wall_right_col))) &&
                     (blk_row > 5'(game_pkg::wall_top_row));

  // top and bottom rows span the full width
  assign flat_wall = (blk_row == 5'(game_pkg::wall_top_row)) ||
                     (blk_row == 5'(game_pkg::wall_bottom_row));

  assign is_wall = side_wall || flat_wall;

  // ------------------------------
  // colour priority
  // ------------------------------
  // tile first, then wall, then background
  always_comb begin
    color_d = game_pkg::color_black;
    if (sync.blank_n) begin
      if (tile != game_pkg::tile_empty) begin
        case (tile)
          game_pkg::tile_apple: color_d = game_pkg::color_apple;
          game_pkg::tile_head:  color_d = game_pkg::color_head;
          game_pkg::tile_body:  color_d = game_pkg::color_body;
          default:              color_d = game_pkg::color_black;
        endcase
      end else if (is_wall) begin
        color_d = game_pkg::color_wall;
      end
    end
  end

  // ------------------------------
  // output stage
  // ------------------------------
  // colour and sync share one register, so they stay aligned
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rgb      <= game_pkg::color_black;
      sync_out <= vga_timing_pkg::sync_idle;
    end else begin
      rgb      <= color_d;
      sync_out <= sync;
    end
  end

endmodule

// File: hw/snake_display.sv
`timescale 1ns/1ps

// snake game video peripheral, register bus in, vga out
module snake_display (
  input  logic                clk,
  input  logic                reset,
  input  logic                chipselect,
  input  logic                write,
  input  game_pkg::bus_addr_t address,
  input  logic [7:0]          writedata,
  output logic [7:0]          vga_r,
  output logic [7:0]          vga_g,
  output logic [7:0]          vga_b,
  output logic                vga_clk,
  output logic                vga_hs,
  output logic                vga_vs,
  output logic                vga_blank_n,
  output logic                vga_sync_n
);

  vga_timing_pkg::raster_pos_t pos;
  vga_timing_pkg::sync_t       sync;
  vga_timing_pkg::sync_t       sync_out;
  game_pkg::tile_t             tile;
  game_pkg::rgb_t              rgb;

  // ------------------------------
  // raster, map, renderer
  // ------------------------------
  vga_timing timing_i (
    .clk   (clk),
    .reset (reset),
    .pos   (pos),
    .sync  (sync)
  );

  tile_map map_i (
    .clk        (clk),
    .reset      (reset),
    .chipselect (chipselect),
    .write      (write),
    .address    (address),
    .writedata  (writedata),
    .pos        (pos),
    .tile       (tile)
  );

  pixel_renderer render_i (
    .clk      (clk),
    .reset    (reset),
    .pos      (pos),
    .sync     (sync),
    .tile     (tile),
    .rgb      (rgb),
    .sync_out (sync_out)
  );

  // split registered groups onto the pins
  assign vga_r       = rgb.r;
  assign vga_g       = rgb.g;
  assign vga_b       = rgb.b;
  assign vga_clk     = sync_out.pix_clk;
  assign vga_hs      = sync_out.hs;
  assign vga_vs      = sync_out.vs;
  assign vga_blank_n = sync_out.blank_n;
  // no sync on green
  assign vga_sync_n  = 1'b0;

endmodule

// File: test/snake_display_properties.sv
`timescale 1ns/1ps

// checker bound into snake_display, rebuilds raster and map from the bus pins
module snake_display_properties (
  input logic                clk,
  input logic                reset,
  input logic                chipselect,
  input logic                write,
  input game_pkg::bus_addr_t address,
  input logic [7:0]          writedata,
  input logic [7:0]          vga_r,
  input logic [7:0]          vga_g,
  input logic [7:0]          vga_b,
  input logic                vga_clk,
  input logic                vga_hs,
  input logic                vga_vs,
  input logic                vga_blank_n,
  input logic                vga_sync_n
);

  // read by the testbench monitor
  int unsigned error_count = 0;

  vga_timing_pkg::hcount_t m_h;
  vga_timing_pkg::hcount_t m_h_q;
  vga_timing_pkg::vcount_t m_v;
  vga_timing_pkg::vcount_t m_v_q;
  game_pkg::map_idx_t      shadow_col;
  game_pkg::map_idx_t      shadow_row;
  game_pkg::tile_t         shadow [game_pkg::map_dim][game_pkg::map_dim];
  int                      px_x;
  int                      px_y;
  logic                    visible;
  logic                    on_wall;
  game_pkg::tile_t         tile_here;
  vga_timing_pkg::sync_t   exp_sync;
  vga_timing_pkg::sync_t   exp_sync_q;
  game_pkg::rgb_t          exp_rgb;
  game_pkg::rgb_t          exp_rgb_q;
  game_pkg::rgb_t          rgb_seen;

  // ------------------------------
  // model raster, restarts at reset
  // ------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      m_h <= '0;
      m_v <= '0;
    end else if (m_h == vga_timing_pkg::h_total - 11'd1) begin
      m_h <= '0;
      m_v <= (m_v == vga_timing_pkg::v_total - 10'd1) ? '0 : m_v + 10'd1;
    end else begin
      m_h <= m_h + 11'd1;
    end
  end

  // shadow map, snooped off the bus
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      shadow_col <= '0;
      shadow_row <= '0;
      for (int r = 0; r < game_pkg::map_dim; r++) begin
        for (int c = 0; c < game_pkg::map_dim; c++) begin
          shadow[r][c] <= game_pkg::tile_empty;
        end
      end
    end else if (chipselect && write) begin
      if (address == game_pkg::reg_x) begin
        shadow_col <= writedata[3:0];
      end else if (address == game_pkg::reg_y) begin
        shadow_row <= writedata[3:0];
      end else if (address == game_pkg::reg_tile) begin
        shadow[shadow_row][shadow_col] <= writedata[1:0];
      end
    end
  end

  // ------------------------------
  // expected pixel, in pixel units
  // ------------------------------
  always_comb begin
    px_x = int'(m_h) / 2;
    px_y = int'(m_v);
    visible = (m_h < vga_timing_pkg::h_active) && (m_v < vga_timing_pkg::v_active);
    // top band, bottom band, then side columns below the top band
    on_wall = (px_y >= game_pkg::wall_px && px_y < 2 * game_pkg::wall_px) ||
              (px_y >= 14 * game_pkg::wall_px && px_y < 15 * game_pkg::wall_px) ||
              ((px_x < game_pkg::wall_px || px_x >= 19 * game_pkg::wall_px) &&
               px_y >= 2 * game_pkg::wall_px);
    tile_here = game_pkg::tile_empty;
    if (px_x < game_pkg::map_px && px_y < game_pkg::map_px) begin
      tile_here = shadow[px_y / game_pkg::tile_px][px_x / game_pkg::tile_px];
    end
    exp_rgb = game_pkg::color_black;
    if (visible) begin
      case (tile_here)
        game_pkg::tile_apple: exp_rgb = game_pkg::color_apple;
        game_pkg::tile_head:  exp_rgb = game_pkg::color_head;
        game_pkg::tile_body:  exp_rgb = game_pkg::color_body;
        default:              exp_rgb = on_wall ? game_pkg::color_wall : game_pkg::color_black;
      endcase
    end
    // 1312..1503 and lines 490..491, both active low
    exp_sync.hs = !((int'(m_h) >= 1312) && (int'(m_h) <= 1503));
    exp_sync.vs = !((int'(m_v) == 490) || (int'(m_v) == 491));
    exp_sync.blank_n = visible;
    exp_sync.pix_clk = m_h[0];
  end

  // one clock behind, like the output stage
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      exp_sync_q <= 4'b1100;
      exp_rgb_q  <= '0;
      m_h_q      <= '0;
      m_v_q      <= '0;
    end else begin
      exp_sync_q <= exp_sync;
      exp_rgb_q  <= exp_rgb;
      m_h_q      <= m_h;
      m_v_q      <= m_v;
    end
  end

  assign rgb_seen = {vga_r, vga_g, vga_b};

  // ------------------------------
  // assertions
  // ------------------------------
  a_reset_idle: assert property (@(posedge clk) (reset && $past(reset)) |->
      (vga_hs && vga_vs && !vga_blank_n && !vga_clk && rgb_seen == 24'h0))
    else begin
      $error("Fail in reset vga_hs %h vga_vs %h vga_blank_n %h vga_clk %h rgb %h",
             vga_hs, vga_vs, vga_blank_n, vga_clk, rgb_seen);
      error_count++;
    end

  a_hs: assert property (@(posedge clk) disable iff (reset) vga_hs == exp_sync_q.hs)
    else begin
      $error("Fail vga_hs %h expected %h", vga_hs, exp_sync_q.hs);
      error_count++;
    end

  a_vs: assert property (@(posedge clk) disable iff (reset) vga_vs == exp_sync_q.vs)
    else begin
      $error("Fail vga_vs %h expected %h", vga_vs, exp_sync_q.vs);
      error_count++;
    end

  a_blank: assert property (@(posedge clk) disable iff (reset)
      vga_blank_n == exp_sync_q.blank_n)
    else begin
      $error("Fail vga_blank_n %h expected %h", vga_blank_n, exp_sync_q.blank_n);
      error_count++;
    end

  a_pix_clk: assert property (@(posedge clk) disable iff (reset)
      vga_clk == exp_sync_q.pix_clk)
    else begin
      $error("Fail vga_clk %h expected %h", vga_clk, exp_sync_q.pix_clk);
      error_count++;
    end

  a_rgb: assert property (@(posedge clk) disable iff (reset) rgb_seen == exp_rgb_q)
    else begin
      $error("Fail {vga_r, vga_g, vga_b} %h expected %h", rgb_seen, exp_rgb_q);
      error_count++;
    end

  a_sync_n: assert property (@(posedge clk) !vga_sync_n)
    else begin
      $error("Fail vga_sync_n %h expected 0", vga_sync_n);
      error_count++;
    end

endmodule

bind snake_display snake_display_properties props_i (.*);

// File: test/snake_display_tb.sv
`timescale 1ns/1ps

module snake_display_tb;

  // one frame plus some slack
  localparam int frame_limit = 1600 * 525 + 64;

  logic                clk;
  logic                reset;
  logic                chipselect;
  logic                write;
  game_pkg::bus_addr_t address;
  logic [7:0]          writedata;
  logic [7:0]          vga_r;
  logic [7:0]          vga_g;
  logic [7:0]          vga_b;
  logic                vga_clk;
  logic                vga_hs;
  logic                vga_vs;
  logic                vga_blank_n;
  logic                vga_sync_n;

  snake_display dut_i (.*);

  // 125 MHz here, period only sets the step
  always #4 clk = ~clk;

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic bus_write(input game_pkg::bus_addr_t addr, input logic [7:0] data);
    @(negedge clk);
    chipselect = 1'b1;
    write      = 1'b1;
    address    = addr;
    writedata  = data;
    @(negedge clk);
    chipselect = 1'b0;
    write      = 1'b0;
  endtask

  // column, row, then the code itself
  task automatic put_tile(input int col, input int row, input game_pkg::tile_t code);
    bus_write(game_pkg::reg_x, 8'(col));
    bus_write(game_pkg::reg_y, 8'(row));
    bus_write(game_pkg::reg_tile, {6'd0, code});
  endtask

  // runs up to the next model frame start
  task automatic wait_frame();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!(dut_i.props_i.m_h == '0 && dut_i.props_i.m_v == '0)) begin
      @(negedge clk);
      cycles++;
      if (cycles > frame_limit) begin
        stop_run("timeout while waiting for a frame start");
      end
    end
  endtask

  // output stage showing raster position hc, vc
  task automatic wait_pixel(input int hc, input int vc);
    int cycles;
    cycles = 0;
    while (!(int'(dut_i.props_i.m_h_q) == hc && int'(dut_i.props_i.m_v_q) == vc)) begin
      @(negedge clk);
      cycles++;
      if (cycles > frame_limit) begin
        stop_run("timeout while waiting for a pixel position");
      end
    end
  endtask

  function automatic game_pkg::rgb_t palette(input game_pkg::tile_t code);
    case (code)
      game_pkg::tile_apple: return game_pkg::color_apple;
      game_pkg::tile_head:  return game_pkg::color_head;
      game_pkg::tile_body:  return game_pkg::color_body;
      default:              return game_pkg::color_black;
    endcase
  endfunction

  task automatic check_hex(input string name, input logic [23:0] got, input logic [23:0] exp);
    if (got !== exp) begin
      $display("Fail %s got %h expected %h", name, got, exp);
      stop_run("colour mismatch on a written tile");
    end
  endtask

  // bound checker raised an error
  always @(negedge clk) begin
    if (dut_i.props_i.error_count != 0) begin
      stop_run("concurrent assertion failed in the bound checker");
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin
    int              cols [8];
    int              rows [8];
    game_pkg::tile_t code;
    void'($urandom(86009));
    clk        = 1'b0;
    reset      = 1'b1;
    chipselect = 1'b0;
    write      = 1'b0;
    address    = '0;
    writedata  = '0;
    repeat (16) @(negedge clk);
    reset = 1'b0;

    // empty map, wall and background for a whole frame
    wait_frame();

    // random tiles, codes 1 to 3
    for (int n = 0; n < 8; n++) begin
      cols[n] = int'($urandom % 16);
      rows[n] = int'($urandom % 16);
      code    = game_pkg::tile_t'(1 + $urandom % 3);
      put_tile(cols[n], rows[n], code);
    end
    // sits on the top wall band, near the left edge
    put_tile(1, 3, game_pkg::tile_head);
    wait_frame();
    wait_frame();
    // middle of tile (1,3)
    wait_pixel(48, 56);
    check_hex("{vga_r, vga_g, vga_b}", {vga_r, vga_g, vga_b}, palette(game_pkg::tile_head));

    // back to empty, then writes to unused addresses
    put_tile(1, 3, game_pkg::tile_empty);
    for (int n = 0; n < 4; n++) begin
      put_tile(cols[n], rows[n], game_pkg::tile_empty);
    end
    for (int n = 0; n < 6; n++) begin
      bus_write(game_pkg::bus_addr_t'(3 + $urandom % 5), 8'($urandom));
    end
    // lands on the position latched before the unused writes
    bus_write(game_pkg::reg_tile, {6'd0, game_pkg::tile_body});
    wait_frame();
    wait_frame();

    // reset again in the middle of a frame
    repeat (int'($urandom % 5000)) @(negedge clk);
    reset = 1'b1;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    repeat (4000) @(negedge clk);

    if (dut_i.props_i.error_count == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      stop_run("assertion failures counted at the end of the run");
    end
  end

endmodule

// File: src.f
hw/vga_timing_pkg.sv
hw/game_pkg.sv
hw/vga_timing.sv
hw/tile_map.sv
hw/pixel_renderer.sv
hw/snake_display.sv
test/snake_display_properties.sv
test/snake_display_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the snake display testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=build
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module snake_display_tb -Mdir "$build_dir" -f src.f
if [ $? -ne 0 ]; then
  echo "compile step returned an error"
  exit 1
fi

# keep counting assertion errors so the testbench can report them itself
"./$build_dir/Vsnake_display_tb" +verilator+error+limit+1000 > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "tests failed" "$log"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
echo "simulation finished cleanly"
exit 0
